// ==== src/scope_config.svh ====
`ifndef SCOPE_CONFIG_SVH
`define SCOPE_CONFIG_SVH

// channel count is tied to the address map
`define SCOPE_N_CH       2
`define SCOPE_DW         14   // sample width
`define SCOPE_RSZ        14   // buffer address width
`define SCOPE_ADDR_USED  20

// register offsets
`define SCOPE_A_CTRL     20'h00000
`define SCOPE_A_TRG      20'h00004
`define SCOPE_A_TRESH0   20'h00008
`define SCOPE_A_TRESH1   20'h0000C
`define SCOPE_A_DLY0     20'h00010
`define SCOPE_A_DEC0     20'h00014
`define SCOPE_A_WPCUR0   20'h00018
`define SCOPE_A_WPTRG0   20'h0001C
`define SCOPE_A_HYST0    20'h00020
`define SCOPE_A_HYST1    20'h00024
`define SCOPE_A_DLY1     20'h00110
`define SCOPE_A_DEC1     20'h00114
`define SCOPE_A_WPCUR1   20'h00118
`define SCOPE_A_WPTRG1   20'h0011C

// buffer windows, matched against addr[19:16]
`define SCOPE_WIN_BUF0   4'h1
`define SCOPE_WIN_BUF1   4'h2

// reset defaults
`define SCOPE_TRESH0_RST 14'd5000
`define SCOPE_TRESH1_RST (-14'sd5000)
`define SCOPE_HYST_RST   14'd20
`define SCOPE_DEC_RST    17'd1

`define SCOPE_TRG_SW     4'h1  // software trigger source

`endif

// ==== src/scope_pkg.sv ====
`default_nettype none

`include "scope_config.svh"

package scope_pkg;

  typedef logic [31:0] sys_data_t;  // bus word
  typedef logic [`SCOPE_ADDR_USED-1:0] sys_addr_t;

  // threshold and hysteresis share the sample width
  typedef logic [`SCOPE_DW-1:0] sample_t;

  typedef logic [31:0] dly_t;  // post-trigger delay in samples
  typedef logic [16:0] dec_t;

  typedef logic [`SCOPE_RSZ-1:0] wptr_t;

  typedef logic [3:0] trg_src_t;
  typedef logic [15:0] acq_state_t;  // per-channel status

endpackage

`default_nettype wire

// ==== src/scope_cmd_decode.sv ====
`default_nettype none

`include "scope_config.svh"

module scope_cmd_decode (
  input  logic                                    adc_clk_i,
  input  logic                                    adc_rstn_i,
  input  scope_pkg::sys_addr_t                    sys_addr_i,
  input  scope_pkg::sys_data_t                    sys_wdata_i,
  input  logic                                    sys_wen_i,
  output logic [`SCOPE_N_CH-1:0]                  arm_o,
  output logic [`SCOPE_N_CH-1:0]                  rst_o,
  output logic [`SCOPE_N_CH-1:0]                  trig_sw_o,
  output logic [`SCOPE_N_CH-1:0]                  we_keep_o,
  output logic [`SCOPE_N_CH-1:0]                  indep_mode_o,
  output logic [`SCOPE_N_CH-1:0]                  new_trg_src_o,
  output scope_pkg::trg_src_t [`SCOPE_N_CH-1:0]   trg_src_o
);

  logic       wr_ctrl;
  logic       wr_trg;
  logic [7:0] ch_byte [`SCOPE_N_CH];

  assign wr_ctrl = sys_wen_i && (sys_addr_i == `SCOPE_A_CTRL);
  assign wr_trg  = sys_wen_i && (sys_addr_i == `SCOPE_A_TRG);

  for (genvar ch = 0; ch < `SCOPE_N_CH; ch++) begin : g_ch
    assign ch_byte[ch] = sys_wdata_i[8*ch +: 8];  // one byte per channel

    // source code is valid together with the new-source strobe
    assign trg_src_o[ch]     = ch_byte[ch][3:0];
    assign new_trg_src_o[ch] = wr_trg && (|ch_byte[ch][3:0]);

    // host waits for ack between accesses, so an arm never repeats back to back
    a_arm_single : assert property (
      @(posedge adc_clk_i) disable iff (!adc_rstn_i)
      arm_o[ch] |=> !arm_o[ch]
    ) else $error("arm pulse on channel %0d held for two cycles", ch);
  end

  always_ff @(posedge adc_clk_i) begin
    if (!adc_rstn_i) begin
      arm_o        <= '0;
      rst_o        <= '0;
      trig_sw_o    <= '0;
      we_keep_o    <= '0;
      indep_mode_o <= '0;
    end else begin
      for (int ch = 0; ch < `SCOPE_N_CH; ch++) begin
        arm_o[ch]     <= wr_ctrl && ch_byte[ch][0];
        rst_o[ch]     <= wr_ctrl && ch_byte[ch][1];  // acquisition reset
        trig_sw_o[ch] <= wr_trg && (ch_byte[ch][3:0] == `SCOPE_TRG_SW);

        // zero byte leaves the mode bits alone
        if (wr_ctrl && (|ch_byte[ch])) begin
          we_keep_o[ch]    <= ch_byte[ch][3];  // keep writing after trigger
          indep_mode_o[ch] <= ch_byte[ch][5];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/scope_setting_regs.sv ====
`default_nettype none

`include "scope_config.svh"

module scope_setting_regs (
  input  logic                                   adc_clk_i,
  input  logic                                   adc_rstn_i,
  input  scope_pkg::sys_addr_t                   sys_addr_i,
  input  scope_pkg::sys_data_t                   sys_wdata_i,
  input  logic                                   sys_wen_i,
  output scope_pkg::sample_t [`SCOPE_N_CH-1:0]   tresh_o,
  output scope_pkg::sample_t [`SCOPE_N_CH-1:0]   hyst_o,
  output scope_pkg::dly_t [`SCOPE_N_CH-1:0]      dly_o,
  output scope_pkg::dec_t [`SCOPE_N_CH-1:0]      dec_o,
  output logic [`SCOPE_N_CH-1:0]                 dec1_o
);

  localparam int SW = $bits(scope_pkg::sample_t);
  localparam int LW = $bits(scope_pkg::dly_t);
  localparam int CW = $bits(scope_pkg::dec_t);

  always_ff @(posedge adc_clk_i) begin
    if (!adc_rstn_i) begin
      tresh_o[0] <= `SCOPE_TRESH0_RST;
      tresh_o[1] <= `SCOPE_TRESH1_RST;  // negative level on ch1
      for (int ch = 0; ch < `SCOPE_N_CH; ch++) begin
        hyst_o[ch] <= `SCOPE_HYST_RST;
        dly_o[ch]  <= '0;
        dec_o[ch]  <= `SCOPE_DEC_RST;
      end
    end else if (sys_wen_i) begin
      // only the low field bits are kept
      case (sys_addr_i)
        `SCOPE_A_TRESH0: tresh_o[0] <= sys_wdata_i[SW-1:0];
        `SCOPE_A_TRESH1: tresh_o[1] <= sys_wdata_i[SW-1:0];
        `SCOPE_A_HYST0:  hyst_o[0]  <= sys_wdata_i[SW-1:0];
        `SCOPE_A_HYST1:  hyst_o[1]  <= sys_wdata_i[SW-1:0];
        `SCOPE_A_DLY0:   dly_o[0]   <= sys_wdata_i[LW-1:0];
        `SCOPE_A_DLY1:   dly_o[1]   <= sys_wdata_i[LW-1:0];
        `SCOPE_A_DEC0:   dec_o[0]   <= sys_wdata_i[CW-1:0];
        `SCOPE_A_DEC1:   dec_o[1]   <= sys_wdata_i[CW-1:0];
        default: ;
      endcase
    end
  end

  // no decimation, core can bypass its averaging path
  for (genvar ch = 0; ch < `SCOPE_N_CH; ch++) begin : g_dec1
    assign dec1_o[ch] = (dec_o[ch] == scope_pkg::dec_t'(1));
  end

endmodule

`default_nettype wire

// ==== src/scope_chan_follow.sv ====
`default_nettype none

`include "scope_config.svh"

module scope_chan_follow (
  input  logic [`SCOPE_N_CH-1:0]                 indep_mode_i,
  input  logic [`SCOPE_N_CH-1:0]                 arm_i,
  input  logic [`SCOPE_N_CH-1:0]                 rst_i,
  input  logic [`SCOPE_N_CH-1:0]                 trig_sw_i,
  input  logic [`SCOPE_N_CH-1:0]                 we_keep_i,
  input  logic [`SCOPE_N_CH-1:0]                 new_trg_src_i,
  input  scope_pkg::trg_src_t [`SCOPE_N_CH-1:0]  trg_src_i,
  input  scope_pkg::dly_t [`SCOPE_N_CH-1:0]      dly_i,
  input  scope_pkg::dec_t [`SCOPE_N_CH-1:0]      dec_i,
  input  logic [`SCOPE_N_CH-1:0]                 dec1_i,
  output logic [`SCOPE_N_CH-1:0]                 arm_o,
  output logic [`SCOPE_N_CH-1:0]                 rst_o,
  output logic [`SCOPE_N_CH-1:0]                 trig_sw_o,
  output logic [`SCOPE_N_CH-1:0]                 we_keep_o,
  output logic [`SCOPE_N_CH-1:0]                 new_trg_src_o,
  output scope_pkg::trg_src_t [`SCOPE_N_CH-1:0]  trg_src_o,
  output scope_pkg::dly_t [`SCOPE_N_CH-1:0]      dly_o,
  output scope_pkg::dec_t [`SCOPE_N_CH-1:0]      dec_o,
  output logic [`SCOPE_N_CH-1:0]                 dec1_o
);

  // ch0 is always the leader
  assign arm_o[0]         = arm_i[0];
  assign rst_o[0]         = rst_i[0];
  assign trig_sw_o[0]     = trig_sw_i[0];
  assign we_keep_o[0]     = we_keep_i[0];
  assign new_trg_src_o[0] = new_trg_src_i[0];
  assign trg_src_o[0]     = trg_src_i[0];
  assign dly_o[0]         = dly_i[0];
  assign dec_o[0]         = dec_i[0];
  assign dec1_o[0]        = dec1_i[0];

  for (genvar ch = 1; ch < `SCOPE_N_CH; ch++) begin : g_follow
    logic own;  // channel runs from its own registers

    assign own = indep_mode_i[ch];

    assign arm_o[ch]         = own ? arm_i[ch]         : arm_i[0];
    assign rst_o[ch]         = own ? rst_i[ch]         : rst_i[0];
    assign trig_sw_o[ch]     = own ? trig_sw_i[ch]     : trig_sw_i[0];
    assign we_keep_o[ch]     = own ? we_keep_i[ch]     : we_keep_i[0];
    assign new_trg_src_o[ch] = own ? new_trg_src_i[ch] : new_trg_src_i[0];
    assign trg_src_o[ch]     = own ? trg_src_i[ch]     : trg_src_i[0];
    assign dly_o[ch]         = own ? dly_i[ch]         : dly_i[0];
    assign dec_o[ch]         = own ? dec_i[ch]         : dec_i[0];
    assign dec1_o[ch]        = own ? dec1_i[ch]        : dec1_i[0];
  end

endmodule

`default_nettype wire

// ==== src/scope_read_mux.sv ====
`default_nettype none

`include "scope_config.svh"

module scope_read_mux (
  input  logic                                      adc_clk_i,
  input  logic                                      adc_rstn_i,
  input  scope_pkg::sys_addr_t                      sys_addr_i,
  input  logic                                      sys_wen_i,
  input  logic                                      sys_ren_i,
  input  scope_pkg::sample_t [`SCOPE_N_CH-1:0]      tresh_i,
  input  scope_pkg::sample_t [`SCOPE_N_CH-1:0]      hyst_i,
  input  scope_pkg::dly_t [`SCOPE_N_CH-1:0]         dly_i,
  input  scope_pkg::dec_t [`SCOPE_N_CH-1:0]         dec_i,
  input  scope_pkg::acq_state_t [`SCOPE_N_CH-1:0]   adc_state_i,
  input  scope_pkg::acq_state_t [`SCOPE_N_CH-1:0]   trg_state_i,
  input  scope_pkg::wptr_t [`SCOPE_N_CH-1:0]        wp_cur_i,
  input  scope_pkg::wptr_t [`SCOPE_N_CH-1:0]        wp_trig_i,
  input  scope_pkg::sample_t [`SCOPE_N_CH-1:0]      bram_rd_dat_i,
  input  logic [`SCOPE_N_CH-1:0]                    bram_ack_i,
  output scope_pkg::sys_data_t                      sys_rdata_o,
  output logic                                      sys_ack_o,
  output logic                                      sys_err_o
);

  logic                 sys_en;
  logic [3:0]           win_sel;
  logic                 buf_win;
  scope_pkg::sys_data_t reg_data;
  scope_pkg::sys_data_t rd_data;
  logic                 rd_ack;

  assign sys_en  = sys_wen_i | sys_ren_i;
  assign win_sel = sys_addr_i[19:16];
  assign buf_win = (win_sel == `SCOPE_WIN_BUF0) || (win_sel == `SCOPE_WIN_BUF1);

  // register space, unmapped reads as zero
  always_comb begin
    case (sys_addr_i)
      `SCOPE_A_CTRL:   reg_data = {adc_state_i[1], adc_state_i[0]};
      `SCOPE_A_TRG:    reg_data = {trg_state_i[1], trg_state_i[0]};
      `SCOPE_A_TRESH0: reg_data = scope_pkg::sys_data_t'(tresh_i[0]);
      `SCOPE_A_TRESH1: reg_data = scope_pkg::sys_data_t'(tresh_i[1]);
      `SCOPE_A_HYST0:  reg_data = scope_pkg::sys_data_t'(hyst_i[0]);
      `SCOPE_A_HYST1:  reg_data = scope_pkg::sys_data_t'(hyst_i[1]);
      `SCOPE_A_DLY0:   reg_data = dly_i[0];
      `SCOPE_A_DLY1:   reg_data = dly_i[1];
      `SCOPE_A_DEC0:   reg_data = scope_pkg::sys_data_t'(dec_i[0]);
      `SCOPE_A_DEC1:   reg_data = scope_pkg::sys_data_t'(dec_i[1]);
      `SCOPE_A_WPCUR0: reg_data = scope_pkg::sys_data_t'(wp_cur_i[0]);
      `SCOPE_A_WPCUR1: reg_data = scope_pkg::sys_data_t'(wp_cur_i[1]);
      `SCOPE_A_WPTRG0: reg_data = scope_pkg::sys_data_t'(wp_trig_i[0]);
      `SCOPE_A_WPTRG1: reg_data = scope_pkg::sys_data_t'(wp_trig_i[1]);
      default:         reg_data = '0;
    endcase
  end

  // buffer windows take their ack from the buffer
  always_comb begin
    case (win_sel)
      `SCOPE_WIN_BUF0: begin
        rd_ack  = bram_ack_i[0];
        rd_data = scope_pkg::sys_data_t'(bram_rd_dat_i[0]);
      end
      `SCOPE_WIN_BUF1: begin
        rd_ack  = bram_ack_i[1];
        rd_data = scope_pkg::sys_data_t'(bram_rd_dat_i[1]);
      end
      default: begin
        rd_ack  = sys_en;
        rd_data = reg_data;
      end
    endcase
  end

  always_ff @(posedge adc_clk_i) begin
    if (!adc_rstn_i) begin
      sys_ack_o <= 1'b0;
    end else begin
      sys_ack_o <= rd_ack;
    end
  end

  always_ff @(posedge adc_clk_i) begin
    sys_rdata_o <= rd_data;
  end

  assign sys_err_o = 1'b0;  // no error responses on this bus

  // register accesses always finish in one cycle
  a_reg_ack : assert property (
    @(posedge adc_clk_i) disable iff (!adc_rstn_i)
    (sys_en && !buf_win) |=> sys_ack_o
  ) else $error("register access at %h not acknowledged", $past(sys_addr_i));

endmodule

`default_nettype wire

// ==== src/scope_cfg_top.sv ====
`default_nettype none

module scope_cfg_top (
  input  logic                              adc_clk_i,
  input  logic                              adc_rstn_i,
  input  scope_pkg::sys_data_t              sys_addr_i,   // low 20 bits decoded
  input  scope_pkg::sys_data_t              sys_wdata_i,
  input  logic                              sys_wen_i,
  input  logic                              sys_ren_i,
  output scope_pkg::sys_data_t              sys_rdata_o,
  output logic                              sys_ack_o,
  output logic                              sys_err_o,
  input  scope_pkg::acq_state_t [1:0]       adc_state_i,
  input  scope_pkg::acq_state_t [1:0]       trg_state_i,
  input  scope_pkg::wptr_t [1:0]            wp_cur_i,
  input  scope_pkg::wptr_t [1:0]            wp_trig_i,
  input  scope_pkg::sample_t [1:0]          bram_rd_dat_i,
  input  logic [1:0]                        bram_ack_i,
  output logic [1:0]                        adc_arm_do_o,
  output logic [1:0]                        adc_rst_do_o,
  output logic [1:0]                        adc_trig_sw_o,
  output logic [1:0]                        adc_we_keep_o,
  output logic [1:0]                        indep_mode_o,
  output logic [1:0]                        new_trg_src_o,
  output scope_pkg::trg_src_t [1:0]         trg_src_o,
  output logic [1:0]                        set_dec1_o,
  output scope_pkg::sample_t [1:0]          set_tresh_o,
  output scope_pkg::sample_t [1:0]          set_hyst_o,
  output scope_pkg::dly_t [1:0]             set_dly_o,
  output scope_pkg::dec_t [1:0]             set_dec_o
);

  // per-channel values before the follow stage
  logic [1:0]                arm_raw;
  logic [1:0]                rst_raw;
  logic [1:0]                trig_sw_raw;
  logic [1:0]                we_keep_raw;
  logic [1:0]                new_trg_src_raw;
  scope_pkg::trg_src_t [1:0] trg_src_raw;
  scope_pkg::dly_t [1:0]     dly_raw;
  scope_pkg::dec_t [1:0]     dec_raw;
  logic [1:0]                dec1_raw;

  scope_cmd_decode u_cmd (
    .adc_clk_i     (adc_clk_i),
    .adc_rstn_i    (adc_rstn_i),
    .sys_addr_i    (sys_addr_i[$bits(scope_pkg::sys_addr_t)-1:0]),
    .sys_wdata_i   (sys_wdata_i),
    .sys_wen_i     (sys_wen_i),
    .arm_o         (arm_raw),
    .rst_o         (rst_raw),
    .trig_sw_o     (trig_sw_raw),
    .we_keep_o     (we_keep_raw),
    .indep_mode_o  (indep_mode_o),
    .new_trg_src_o (new_trg_src_raw),
    .trg_src_o     (trg_src_raw)
  );

  scope_setting_regs u_set (
    .adc_clk_i   (adc_clk_i),
    .adc_rstn_i  (adc_rstn_i),
    .sys_addr_i  (sys_addr_i[$bits(scope_pkg::sys_addr_t)-1:0]),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .tresh_o     (set_tresh_o),
    .hyst_o      (set_hyst_o),
    .dly_o       (dly_raw),
    .dec_o       (dec_raw),
    .dec1_o      (dec1_raw)
  );

  scope_chan_follow u_follow (
    .indep_mode_i  (indep_mode_o),
    .arm_i         (arm_raw),
    .rst_i         (rst_raw),
    .trig_sw_i     (trig_sw_raw),
    .we_keep_i     (we_keep_raw),
    .new_trg_src_i (new_trg_src_raw),
    .trg_src_i     (trg_src_raw),
    .dly_i         (dly_raw),
    .dec_i         (dec_raw),
    .dec1_i        (dec1_raw),
    .arm_o         (adc_arm_do_o),
    .rst_o         (adc_rst_do_o),
    .trig_sw_o     (adc_trig_sw_o),
    .we_keep_o     (adc_we_keep_o),
    .new_trg_src_o (new_trg_src_o),
    .trg_src_o     (trg_src_o),
    .dly_o         (set_dly_o),
    .dec_o         (set_dec_o),
    .dec1_o        (set_dec1_o)
  );

  // readback shows each channel's own registers
  scope_read_mux u_rd (
    .adc_clk_i     (adc_clk_i),
    .adc_rstn_i    (adc_rstn_i),
    .sys_addr_i    (sys_addr_i[$bits(scope_pkg::sys_addr_t)-1:0]),
    .sys_wen_i     (sys_wen_i),
    .sys_ren_i     (sys_ren_i),
    .tresh_i       (set_tresh_o),
    .hyst_i        (set_hyst_o),
    .dly_i         (dly_raw),
    .dec_i         (dec_raw),
    .adc_state_i   (adc_state_i),
    .trg_state_i   (trg_state_i),
    .wp_cur_i      (wp_cur_i),
    .wp_trig_i     (wp_trig_i),
    .bram_rd_dat_i (bram_rd_dat_i),
    .bram_ack_i    (bram_ack_i),
    .sys_rdata_o   (sys_rdata_o),
    .sys_ack_o     (sys_ack_o),
    .sys_err_o     (sys_err_o)
  );

endmodule

`default_nettype wire

// ==== tests/tb_scope_cfg_cases.svh ====
`ifndef TB_SCOPE_CFG_CASES_SVH
`define TB_SCOPE_CFG_CASES_SVH

// write columns: addr, data, set output after write,
//   arm, rst, trig_sw, keep, indep, new_src, src{1,0}, dec1
// read columns: addr, expected read data
// status reads take their expected value from the random status inputs
task automatic load_cases();
  // reset defaults
  add_read(`SCOPE_A_TRESH0, 32'd5000);
  add_read(`SCOPE_A_TRESH1, 32'h0000_2C78);
  add_read(`SCOPE_A_HYST0,  32'd20);
  add_read(`SCOPE_A_HYST1,  32'd20);
  add_read(`SCOPE_A_DEC0,   32'd1);
  add_read(`SCOPE_A_DEC1,   32'd1);
  add_read(`SCOPE_A_DLY0,   32'd0);
  add_read(`SCOPE_A_DLY1,   32'd0);

  // settings truncate to their field width
  add_write(`SCOPE_A_TRESH0, 32'hFFFF_1234, 32'h1234,
            2'b00, 2'b00, 2'b00, 2'b00, 2'b00, 2'b00, 8'h00, 2'b11);
  add_read(`SCOPE_A_TRESH0, 32'h0000_1234);
  add_write(`SCOPE_A_HYST1, 32'h0000_7FFF, 32'h3FFF,
            2'b00, 2'b00, 2'b00, 2'b00, 2'b00, 2'b00, 8'h00, 2'b11);
  add_read(`SCOPE_A_HYST1, 32'h0000_3FFF);
  add_write(`SCOPE_A_DLY0, 32'hDEAD_BEEF, 32'hDEAD_BEEF,
            2'b00, 2'b00, 2'b00, 2'b00, 2'b00, 2'b00, 8'h00, 2'b11);
  add_read(`SCOPE_A_DLY0, 32'hDEAD_BEEF);
  add_read(`SCOPE_A_DLY1, 32'h0000_0000);  // own register, not the followed one
  // ch1 output keeps following ch0
  add_write(`SCOPE_A_DLY1, 32'h0000_0055, 32'hDEAD_BEEF,
            2'b00, 2'b00, 2'b00, 2'b00, 2'b00, 2'b00, 8'h00, 2'b11);
  add_read(`SCOPE_A_DLY1, 32'h0000_0055);
  add_write(`SCOPE_A_DEC0, 32'hFFFF_0005, 32'h1_0005,
            2'b00, 2'b00, 2'b00, 2'b00, 2'b00, 2'b00, 8'h00, 2'b00);
  add_read(`SCOPE_A_DEC0, 32'h0001_0005);
  add_write(`SCOPE_A_DEC0, 32'h0000_0001, 32'h1,
            2'b00, 2'b00, 2'b00, 2'b00, 2'b00, 2'b00, 8'h00, 2'b11);

  // arm, reset and mode bits
  add_write(`SCOPE_A_CTRL, 32'h0000_000B, 32'h0,
            2'b11, 2'b11, 2'b00, 2'b11, 2'b00, 2'b00, 8'h00, 2'b11);
  add_write(`SCOPE_A_CTRL, 32'h0000_2000, 32'h0,
            2'b00, 2'b00, 2'b00, 2'b01, 2'b10, 2'b00, 8'h00, 2'b11);
  add_write(`SCOPE_A_CTRL, 32'h0000_0001, 32'h0,
            2'b01, 2'b00, 2'b00, 2'b00, 2'b10, 2'b00, 8'h00, 2'b11);
  add_write(`SCOPE_A_DEC1, 32'h0000_0003, 32'h3,
            2'b00, 2'b00, 2'b00, 2'b00, 2'b10, 2'b00, 8'h00, 2'b01);
  add_write(`SCOPE_A_TRG,  32'h0000_0001, 32'h0,
            2'b00, 2'b00, 2'b01, 2'b00, 2'b10, 2'b01, 8'h01, 2'b01);
  add_write(`SCOPE_A_CTRL, 32'h0000_2B00, 32'h0,
            2'b10, 2'b10, 2'b00, 2'b10, 2'b10, 2'b00, 8'h00, 2'b01);
  add_write(`SCOPE_A_CTRL, 32'h0000_0000, 32'h0,
            2'b00, 2'b00, 2'b00, 2'b10, 2'b10, 2'b00, 8'h00, 2'b01);
  add_write(`SCOPE_A_CTRL, 32'h0000_0100, 32'h0,
            2'b00, 2'b00, 2'b00, 2'b00, 2'b00, 2'b00, 8'h00, 2'b11);

  // trigger source, ch1 follows again
  add_write(`SCOPE_A_TRG, 32'h0000_0005, 32'h0,
            2'b00, 2'b00, 2'b00, 2'b00, 2'b00, 2'b11, 8'h55, 2'b11);
  add_write(`SCOPE_A_TRG, 32'h0000_0301, 32'h0,
            2'b00, 2'b00, 2'b11, 2'b00, 2'b00, 2'b11, 8'h11, 2'b11);

  // status, pointers, unmapped and buffer windows
  add_status(32'h0000_0000 | `SCOPE_A_CTRL);
  add_status(32'h0000_0000 | `SCOPE_A_TRG);
  add_status(32'h0000_0000 | `SCOPE_A_WPCUR0);
  add_status(32'h0000_0000 | `SCOPE_A_WPCUR1);
  add_status(32'h0000_0000 | `SCOPE_A_WPTRG0);
  add_status(32'h0000_0000 | `SCOPE_A_WPTRG1);
  add_read(32'h0000_0040, 32'h0);
  add_read(32'h0003_0000, 32'h0);
  add_status(32'h0001_0010);
  add_status(32'h0002_0ABC);
  add_status(32'h0001_3FFC);
endtask

`endif

// ==== tests/tb_scope_cfg_top.sv ====
`default_nettype none

`include "scope_config.svh"

module tb_scope_cfg_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam time PERIOD    = 100ns;
  localparam int  ACK_LIMIT = 16;

  typedef struct packed {
    logic        wr;
    logic        st;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
    logic [1:0]  arm;
    logic [1:0]  rst;
    logic [1:0]  tsw;
    logic [1:0]  keep;
    logic [1:0]  ind;
    logic [1:0]  nsrc;
    logic [7:0]  src;
    logic [1:0]  dec1;
  } case_t;

  logic adc_clk_i;
  logic adc_rstn_i;
  scope_pkg::sys_data_t sys_addr_i;
  scope_pkg::sys_data_t sys_wdata_i;
  logic sys_wen_i;
  logic sys_ren_i;
  scope_pkg::sys_data_t sys_rdata_o;
  logic sys_ack_o;
  logic sys_err_o;
  scope_pkg::acq_state_t [1:0] adc_state_i;
  scope_pkg::acq_state_t [1:0] trg_state_i;
  scope_pkg::wptr_t [1:0] wp_cur_i;
  scope_pkg::wptr_t [1:0] wp_trig_i;
  scope_pkg::sample_t [1:0] bram_rd_dat_i;
  logic [1:0] bram_ack_i;
  logic [1:0] adc_arm_do_o;
  logic [1:0] adc_rst_do_o;
  logic [1:0] adc_trig_sw_o;
  logic [1:0] adc_we_keep_o;
  logic [1:0] indep_mode_o;
  logic [1:0] new_trg_src_o;
  scope_pkg::trg_src_t [1:0] trg_src_o;
  logic [1:0] set_dec1_o;
  scope_pkg::sample_t [1:0] set_tresh_o;
  scope_pkg::sample_t [1:0] set_hyst_o;
  scope_pkg::dly_t [1:0] set_dly_o;
  scope_pkg::dec_t [1:0] set_dec_o;

  case_t cases[$];
  int    err_cnt = 0;
  bit    cases_ready = 0;

  scope_cfg_top UUT (.*);

  function automatic void add_write(input logic [31:0] a, input logic [31:0] d,
                                    input logic [31:0] e, input logic [1:0] arm,
                                    input logic [1:0] rst, input logic [1:0] tsw,
                                    input logic [1:0] keep, input logic [1:0] ind,
                                    input logic [1:0] nsrc, input logic [7:0] src,
                                    input logic [1:0] dec1);
    cases.push_back('{1'b1, 1'b0, a, d, e, arm, rst, tsw, keep, ind, nsrc, src, dec1});
  endfunction

  function automatic void add_read(input logic [31:0] a, input logic [31:0] e);
    cases.push_back('{1'b0, 1'b0, a, 32'h0, e, 2'b0, 2'b0, 2'b0, 2'b0, 2'b0, 2'b0,
                      8'h0, 2'b0});
  endfunction

  function automatic void add_status(input logic [31:0] a);
    cases.push_back('{1'b0, 1'b1, a, 32'h0, 32'h0, 2'b0, 2'b0, 2'b0, 2'b0, 2'b0, 2'b0,
                      8'h0, 2'b0});
  endfunction

  `include "tb_scope_cfg_cases.svh"

  // status packing: ch1 in the upper half, narrow fields zero-extended
  function automatic logic [31:0] status_expect(input logic [31:0] a);
    case (a[19:16])
      `SCOPE_WIN_BUF0: return {18'h0, bram_rd_dat_i[0]};
      `SCOPE_WIN_BUF1: return {18'h0, bram_rd_dat_i[1]};
      default: ;
    endcase
    case (a[19:0])
      `SCOPE_A_CTRL:   return {adc_state_i[1], adc_state_i[0]};
      `SCOPE_A_TRG:    return {trg_state_i[1], trg_state_i[0]};
      `SCOPE_A_WPCUR0: return {18'h0, wp_cur_i[0]};
      `SCOPE_A_WPCUR1: return {18'h0, wp_cur_i[1]};
      `SCOPE_A_WPTRG0: return {18'h0, wp_trig_i[0]};
      `SCOPE_A_WPTRG1: return {18'h0, wp_trig_i[1]};
      default:         return 32'h0;
    endcase
  endfunction

  // core-side setting output that belongs to a register address
  function automatic logic [31:0] set_output(input logic [31:0] a);
    case (a[19:0])
      `SCOPE_A_TRESH0: return {18'h0, set_tresh_o[0]};
      `SCOPE_A_TRESH1: return {18'h0, set_tresh_o[1]};
      `SCOPE_A_HYST0:  return {18'h0, set_hyst_o[0]};
      `SCOPE_A_HYST1:  return {18'h0, set_hyst_o[1]};
      `SCOPE_A_DLY0:   return set_dly_o[0];
      `SCOPE_A_DLY1:   return set_dly_o[1];
      `SCOPE_A_DEC0:   return {15'h0, set_dec_o[0]};
      `SCOPE_A_DEC1:   return {15'h0, set_dec_o[1]};
      default:         return 32'h0;
    endcase
  endfunction

  task automatic check(input bit ok, input string msg);
    assert (ok) else begin
      $display("ERROR %0t: %s", $time, msg);
      err_cnt++;
    end
  endtask

  // one access; buffer windows get a late bram ack
  task automatic bus_access(input case_t c, output logic [31:0] rdata);
    int  n;
    int  bdly;
    int  ch;
    bit  bw;
    bit  got;
    n    = 0;
    got  = 0;
    ch   = (c.addr[19:16] == `SCOPE_WIN_BUF1) ? 1 : 0;
    bw   = !c.wr && (c.addr[19:16] == `SCOPE_WIN_BUF0 || c.addr[19:16] == `SCOPE_WIN_BUF1);
    bdly = bw ? int'($urandom % 4) + 1 : 0;
    rdata = 32'h0;
    sys_addr_i  = c.addr;
    sys_wdata_i = c.data;
    sys_wen_i   = c.wr;
    sys_ren_i   = !c.wr;
    if (c.wr) begin
      #45;  // mid write cycle
      check(new_trg_src_o == c.nsrc, $sformatf("new_trg_src_o %b, expected %b",
            new_trg_src_o, c.nsrc));
      if (c.nsrc != 2'b00)
        check(trg_src_o == c.src, $sformatf("trg_src_o %h, expected %h", trg_src_o, c.src));
    end
    while (!got && n < ACK_LIMIT) begin
      @(posedge adc_clk_i);
      #5;
      sys_wen_i = 1'b0;
      sys_ren_i = 1'b0;
      n++;
      if (sys_ack_o) begin
        got   = 1;
        rdata = sys_rdata_o;
        check(!bw || n == bdly + 1, $sformatf("ack at %h came %0d cycles in, bram ack at %0d",
              c.addr, n, bdly));
        check(sys_err_o == 1'b0, "sys_err_o high");
      end
      if (bw)
        bram_ack_i = (n == bdly) ? 2'(1 << ch) : 2'b00;
    end
    if (!got) begin
      $display("No acknowledge for the access at address %h within %0d cycles",
               c.addr, ACK_LIMIT);
      err_cnt++;
    end
  endtask

  initial begin
    adc_clk_i = 1'b0;
    forever #(PERIOD / 2) adc_clk_i = ~adc_clk_i;
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] exp;
    void'($urandom(32'hc880));
    adc_rstn_i    = 1'b0;
    sys_addr_i    = '0;
    sys_wdata_i   = '0;
    sys_wen_i     = 1'b0;
    sys_ren_i     = 1'b0;
    bram_ack_i    = '0;
    adc_state_i   = {16'($urandom), 16'($urandom)};
    trg_state_i   = {16'($urandom), 16'($urandom)};
    wp_cur_i      = {14'($urandom), 14'($urandom)};
    wp_trig_i     = {14'($urandom), 14'($urandom)};
    bram_rd_dat_i = {14'($urandom), 14'($urandom)};
    load_cases();
    cases_ready = 1;
    repeat (4) @(posedge adc_clk_i);
    #5;
    adc_rstn_i = 1'b1;

    check(set_dec1_o == 2'b11, "set_dec1_o not high after reset");
    check(sys_ack_o == 1'b0, "sys_ack_o high after reset");
    check({adc_arm_do_o, adc_rst_do_o, adc_trig_sw_o, adc_we_keep_o} == 8'h0,
          "command pulse high after reset");
    check({indep_mode_o, new_trg_src_o} == 4'h0, "mode bit or new source high after reset");

    foreach (cases[i]) begin
      bus_access(cases[i], rd);
      if (cases[i].wr) begin
        check(adc_arm_do_o == cases[i].arm, $sformatf("case %0d adc_arm_do_o %b, expected %b",
              i, adc_arm_do_o, cases[i].arm));
        check(adc_rst_do_o == cases[i].rst, $sformatf("case %0d adc_rst_do_o %b, expected %b",
              i, adc_rst_do_o, cases[i].rst));
        check(adc_trig_sw_o == cases[i].tsw, $sformatf("case %0d adc_trig_sw_o %b, expected %b",
              i, adc_trig_sw_o, cases[i].tsw));
        check(adc_we_keep_o == cases[i].keep, $sformatf(
              "case %0d adc_we_keep_o %b, expected %b", i, adc_we_keep_o, cases[i].keep));
        check(indep_mode_o == cases[i].ind, $sformatf("case %0d indep_mode_o %b, expected %b",
              i, indep_mode_o, cases[i].ind));
        check(set_dec1_o == cases[i].dec1, $sformatf("case %0d set_dec1_o %b, expected %b",
              i, set_dec1_o, cases[i].dec1));
        // command writes have no setting output
        if (cases[i].addr[19:0] != `SCOPE_A_CTRL && cases[i].addr[19:0] != `SCOPE_A_TRG)
          check(set_output(cases[i].addr) == cases[i].exp, $sformatf(
                "case %0d set output %h, expected %h", i, set_output(cases[i].addr),
                cases[i].exp));
        @(posedge adc_clk_i);
        #5;
        check({adc_arm_do_o, adc_rst_do_o, adc_trig_sw_o} == 6'h0,
              $sformatf("case %0d pulse longer than one cycle", i));
      end else begin
        exp = cases[i].st ? status_expect(cases[i].addr) : cases[i].exp;
        check(rd == exp, $sformatf("case %0d read %h gave %h, expected %h",
              i, cases[i].addr, rd, exp));
      end
    end

    $display("Error count: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // limit grows with the table
  initial begin
    wait (cases_ready);
    #(PERIOD * (cases.size() * (ACK_LIMIT + 4) + 20));
    $display("Timeout: the test sequence did not finish in time");
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== scope_cfg_top.f ====
+incdir+src
+incdir+tests
src/scope_pkg.sv
src/scope_cmd_decode.sv
src/scope_setting_regs.sv
src/scope_chan_follow.sv
src/scope_read_mux.sv
src/scope_cfg_top.sv
tests/tb_scope_cfg_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_scope_cfg_top
FLIST     ?= scope_cfg_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SRCS := $(shell grep -v '^+' $(FLIST)) src/scope_config.svh tests/tb_scope_cfg_cases.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
